// ==== logic/mmt_pkg.sv ====
package mmt_pkg;

	// --------------------
	// Sizes
	localparam int DIM         = 4;
	localparam int NUM_MAT     = 8;
	localparam int ELEMS       = DIM * DIM;
	localparam int QUERIES     = 10;
	localparam int STORE_DEPTH = NUM_MAT * ELEMS;

	// --------------------
	// Widths
	localparam int ELEM_W   = 8;
	localparam int DOT_W    = 18;
	localparam int RESULT_W = 32;
	localparam int IDX_W    = $clog2(NUM_MAT);
	localparam int COORD_W  = $clog2(DIM);
	localparam int ADDR_W   = $clog2(STORE_DEPTH);
	localparam int MODE_W   = 2;
	localparam int QCNT_W   = $clog2(QUERIES);

	typedef logic signed [ELEM_W-1:0]   elem_t;
	typedef logic        [IDX_W-1:0]    mat_idx_t;
	typedef logic        [ADDR_W-1:0]   store_addr_t;
	typedef logic        [COORD_W-1:0]  coord_t;
	typedef logic signed [DOT_W-1:0]    dot_t;
	typedef logic signed [RESULT_W-1:0] result_t;
	typedef logic        [MODE_W-1:0]   mode_t;

	// Transpose selector values
	localparam mode_t MODE_NONE = 2'd0;
	localparam mode_t MODE_TA   = 2'd1;
	localparam mode_t MODE_TB   = 2'd2;
	localparam mode_t MODE_TC   = 2'd3;

	typedef enum logic [1:0] {
		OP_A,
		OP_B,
		OP_C
	} opsel_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_WAIT_Q,
		ST_READ_A,
		ST_READ_B,
		ST_READ_C,
		ST_CALC,
		ST_WAIT_RES
	} ctrl_state_t;

endpackage

// ==== logic/mmt_ifs.sv ====
`timescale 1ns/1ps

// Bank access, one write port and one registered read port
interface mat_store_if;
	logic                 wr_en;
	mmt_pkg::store_addr_t wr_addr;
	mmt_pkg::elem_t       wdata;
	mmt_pkg::store_addr_t rd_addr;
	mmt_pkg::elem_t       rdata;

	modport ctrl (output wr_en, output wr_addr, output wdata, output rd_addr);
	modport store (input wr_en, input wr_addr, input wdata, input rd_addr, output rdata);
	modport sink (input rdata);
endinterface

// Operand array write, aligned with rdata
interface operand_load_if;
	logic             ld_en;
	mmt_pkg::opsel_t  ld_sel;
	mmt_pkg::coord_t  ld_row;
	mmt_pkg::coord_t  ld_col;

	modport ctrl (output ld_en, output ld_sel, output ld_row, output ld_col);
	modport regs (input ld_en, input ld_sel, input ld_row, input ld_col);
endinterface

// One step per product element, row-major
interface mac_step_if;
	logic            step_valid;
	logic            step_first;
	logic            step_last;
	mmt_pkg::coord_t step_row;
	mmt_pkg::coord_t step_col;

	modport ctrl (
		output step_valid,
		output step_first,
		output step_last,
		output step_row,
		output step_col
	);
	modport regs (input step_row, input step_col);
	modport mac (input step_valid, input step_first, input step_last);
endinterface

// ==== logic/mat_store.sv ====
`timescale 1ns/1ps

// Register-array bank of NUM_MAT matrices, row-major per matrix
module mat_store (
	input logic        clk,
	mat_store_if.store mem
);

	mmt_pkg::elem_t bank [mmt_pkg::STORE_DEPTH];

	// --------------------
	// Write port
	always_ff @(posedge clk) begin
		if (mem.wr_en)
			bank[mem.wr_addr] <= mem.wdata;
	end

	// --------------------
	// Read port, data one cycle after the address
	always_ff @(posedge clk) begin
		mem.rdata <= bank[mem.rd_addr];
	end

endmodule

// ==== logic/operand_regs.sv ====
`timescale 1ns/1ps

module operand_regs (
	input  logic           clk,
	input  logic           rst_n,
	mat_store_if.sink      mem,
	operand_load_if.regs   ld,
	mac_step_if.regs       step,
	output mmt_pkg::elem_t a_row [mmt_pkg::DIM],
	output mmt_pkg::elem_t b_col [mmt_pkg::DIM],
	output mmt_pkg::elem_t c_elem
);

	mmt_pkg::elem_t a_m [mmt_pkg::DIM][mmt_pkg::DIM];
	mmt_pkg::elem_t b_m [mmt_pkg::DIM][mmt_pkg::DIM];
	mmt_pkg::elem_t c_m [mmt_pkg::DIM][mmt_pkg::DIM];

	// --------------------
	// Operand load
	// Coordinates arrive already transposed where the mode asks for it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			a_m <= '{default: '0};
			b_m <= '{default: '0};
			c_m <= '{default: '0};
		end else if (ld.ld_en) begin
			case (ld.ld_sel)
				mmt_pkg::OP_A: a_m[ld.ld_row][ld.ld_col] <= mem.rdata;
				mmt_pkg::OP_B: b_m[ld.ld_row][ld.ld_col] <= mem.rdata;
				mmt_pkg::OP_C: c_m[ld.ld_row][ld.ld_col] <= mem.rdata;
				default: ;
			endcase
		end
	end

	// --------------------
	// Step select
	always_comb begin
		for (int k = 0; k < mmt_pkg::DIM; k++) begin
			a_row[k] = a_m[step.step_row][k];
			b_col[k] = b_m[k][step.step_col];
		end
	end

	// C element at the same position as the product element
	assign c_elem = c_m[step.step_row][step.step_col];

endmodule

// ==== logic/trace_mac.sv ====
`timescale 1ns/1ps

module trace_mac (
	input  logic             clk,
	input  logic             rst_n,
	mac_step_if.mac          step,
	input  mmt_pkg::elem_t   a_row [mmt_pkg::DIM],
	input  mmt_pkg::elem_t   b_col [mmt_pkg::DIM],
	input  mmt_pkg::elem_t   c_elem,
	output logic             res_done,
	output logic             out_valid,
	output mmt_pkg::result_t out_value
);

	mmt_pkg::dot_t    dot_sum;
	mmt_pkg::dot_t    s1_dot;
	mmt_pkg::elem_t   s1_c;
	logic             s1_valid;
	logic             s1_first;
	logic             s1_last;
	mmt_pkg::result_t prod;
	mmt_pkg::result_t acc;
	mmt_pkg::result_t acc_nxt;
	logic             done_q;

	// Row of A times column of B
	always_comb begin
		dot_sum = '0;
		for (int k = 0; k < mmt_pkg::DIM; k++)
			dot_sum = dot_sum + mmt_pkg::dot_t'(a_row[k]) * mmt_pkg::dot_t'(b_col[k]);
	end

	// --------------------
	// Stage one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_first <= 1'b0;
			s1_last  <= 1'b0;
		end else begin
			s1_valid <= step.step_valid;
			s1_first <= step.step_valid && step.step_first;
			s1_last  <= step.step_valid && step.step_last;
		end
	end

	always_ff @(posedge clk) begin
		s1_dot <= dot_sum;
		s1_c   <= c_elem;
	end

	// --------------------
	// Stage two, restarts on the first step of a query
	assign prod    = mmt_pkg::result_t'(s1_dot) * mmt_pkg::result_t'(s1_c);
	assign acc_nxt = s1_first ? prod : acc + prod;

	always_ff @(posedge clk) begin
		if (s1_valid)
			acc <= acc_nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_q    <= 1'b0;
			out_value <= '0;
		end else begin
			done_q    <= s1_last;
			out_value <= s1_last ? acc_nxt : '0;
		end
	end

	assign out_valid = done_q;
	assign res_done  = done_q;

endmodule

// ==== logic/mmt_ctrl.sv ====
`timescale 1ns/1ps

module mmt_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  mmt_pkg::elem_t    matrix,
	input  logic              in_valid2,
	input  mmt_pkg::mat_idx_t matrix_idx,
	input  mmt_pkg::mode_t    mode,
	input  logic              res_done,
	mat_store_if.ctrl         mem,
	operand_load_if.ctrl      ld,
	mac_step_if.ctrl          step
);

	localparam mmt_pkg::coord_t COORD_LAST = mmt_pkg::coord_t'(mmt_pkg::DIM - 1);

	mmt_pkg::ctrl_state_t         state;
	mmt_pkg::ctrl_state_t         state_nxt;
	mmt_pkg::store_addr_t         wr_cnt;
	mmt_pkg::coord_t              cnt_row;
	mmt_pkg::coord_t              cnt_col;
	logic [1:0]                   idx_cnt;
	mmt_pkg::mat_idx_t            q_idx [3];
	mmt_pkg::mode_t               q_mode;
	logic [mmt_pkg::QCNT_W-1:0]   q_cnt;
	mmt_pkg::opsel_t              cur_sel;
	logic                         loading;
	logic                         reading;
	logic                         calc;
	logic                         pos_last;
	logic                         swap;

	assign loading  = in_valid &&
		(state == mmt_pkg::ST_IDLE || state == mmt_pkg::ST_LOAD);
	assign reading  = state == mmt_pkg::ST_READ_A || state == mmt_pkg::ST_READ_B ||
		state == mmt_pkg::ST_READ_C;
	assign calc     = state == mmt_pkg::ST_CALC;
	assign pos_last = cnt_row == COORD_LAST && cnt_col == COORD_LAST;

	always_comb begin
		case (state)
			mmt_pkg::ST_READ_B: cur_sel = mmt_pkg::OP_B;
			mmt_pkg::ST_READ_C: cur_sel = mmt_pkg::OP_C;
			default:            cur_sel = mmt_pkg::OP_A;
		endcase
	end

	// Transpose only the operand the mode names
	always_comb begin
		case (q_mode)
			mmt_pkg::MODE_NONE: swap = 1'b0;
			mmt_pkg::MODE_TA:   swap = cur_sel == mmt_pkg::OP_A;
			mmt_pkg::MODE_TB:   swap = cur_sel == mmt_pkg::OP_B;
			default:            swap = cur_sel == mmt_pkg::OP_C;
		endcase
	end

	// Matrix index in the top bits, position row-major below
	assign mem.rd_addr = {q_idx[cur_sel], cnt_row, cnt_col};

	// --------------------
	// State machine
	always_comb begin
		state_nxt = state;
		case (state)
			mmt_pkg::ST_IDLE: begin
				if (in_valid)
					state_nxt = mmt_pkg::ST_LOAD;
			end
			mmt_pkg::ST_LOAD: begin
				if (in_valid && wr_cnt == mmt_pkg::store_addr_t'(mmt_pkg::STORE_DEPTH - 1))
					state_nxt = mmt_pkg::ST_WAIT_Q;
			end
			mmt_pkg::ST_WAIT_Q: begin
				if (in_valid2 && idx_cnt == 2'd2)
					state_nxt = mmt_pkg::ST_READ_A;
			end
			mmt_pkg::ST_READ_A: begin
				if (pos_last)
					state_nxt = mmt_pkg::ST_READ_B;
			end
			mmt_pkg::ST_READ_B: begin
				if (pos_last)
					state_nxt = mmt_pkg::ST_READ_C;
			end
			mmt_pkg::ST_READ_C: begin
				if (pos_last)
					state_nxt = mmt_pkg::ST_CALC;
			end
			mmt_pkg::ST_CALC: begin
				if (pos_last)
					state_nxt = mmt_pkg::ST_WAIT_RES;
			end
			mmt_pkg::ST_WAIT_RES: begin
				if (res_done && q_cnt == mmt_pkg::QCNT_W'(mmt_pkg::QUERIES - 1))
					state_nxt = mmt_pkg::ST_IDLE;
				else if (res_done)
					state_nxt = mmt_pkg::ST_WAIT_Q;
			end
			default: state_nxt = mmt_pkg::ST_IDLE;
		endcase
	end

	// --------------------
	// Counters and query capture
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= mmt_pkg::ST_IDLE;
			wr_cnt  <= '0;
			cnt_row <= '0;
			cnt_col <= '0;
			idx_cnt <= '0;
			q_idx   <= '{default: '0};
			q_mode  <= mmt_pkg::MODE_NONE;
			q_cnt   <= '0;
		end else begin
			state <= state_nxt;
			if (loading)
				wr_cnt <= wr_cnt + 1'b1;
			if (state == mmt_pkg::ST_WAIT_Q && in_valid2) begin
				q_idx[idx_cnt] <= matrix_idx;
				idx_cnt        <= (idx_cnt == 2'd2) ? 2'd0 : idx_cnt + 2'd1;
				if (idx_cnt == 2'd0)
					q_mode <= mode;
			end
			// Shared walk for reads and steps, wraps after the last element
			if (reading || calc) begin
				cnt_col <= (cnt_col == COORD_LAST) ? '0 : cnt_col + 1'b1;
				if (cnt_col == COORD_LAST)
					cnt_row <= (cnt_row == COORD_LAST) ? '0 : cnt_row + 1'b1;
			end
			if (state == mmt_pkg::ST_WAIT_RES && res_done) begin
				if (q_cnt == mmt_pkg::QCNT_W'(mmt_pkg::QUERIES - 1))
					q_cnt <= '0;
				else
					q_cnt <= q_cnt + 1'b1;
			end
		end
	end

	// --------------------
	// Registered enables
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem.wr_en       <= 1'b0;
			ld.ld_en        <= 1'b0;
			step.step_valid <= 1'b0;
			step.step_first <= 1'b0;
			step.step_last  <= 1'b0;
		end else begin
			mem.wr_en       <= loading;
			ld.ld_en        <= reading;
			step.step_valid <= calc;
			step.step_first <= calc && cnt_row == '0 && cnt_col == '0;
			step.step_last  <= calc && pos_last;
		end
	end

	// Load coordinates trail the read address by one cycle, like rdata
	always_ff @(posedge clk) begin
		mem.wr_addr   <= wr_cnt;
		mem.wdata     <= matrix;
		ld.ld_sel     <= cur_sel;
		ld.ld_row     <= swap ? cnt_col : cnt_row;
		ld.ld_col     <= swap ? cnt_row : cnt_col;
		step.step_row <= cnt_row;
		step.step_col <= cnt_col;
	end

endmodule

// ==== logic/mmt_top.sv ====
`timescale 1ns/1ps

module mmt_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  mmt_pkg::elem_t    matrix,
	input  logic              in_valid2,
	input  mmt_pkg::mat_idx_t matrix_idx,
	input  mmt_pkg::mode_t    mode,
	output logic              out_valid,
	output mmt_pkg::result_t  out_value
);

	mmt_pkg::elem_t a_row [mmt_pkg::DIM];
	mmt_pkg::elem_t b_col [mmt_pkg::DIM];
	mmt_pkg::elem_t c_elem;
	logic           res_done;

	mat_store_if    mem_bus ();
	operand_load_if ld_bus ();
	mac_step_if     step_bus ();

	// --------------------
	// Control and storage
	mmt_ctrl mmt_ctrl_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.matrix     (matrix),
		.in_valid2  (in_valid2),
		.matrix_idx (matrix_idx),
		.mode       (mode),
		.res_done   (res_done),
		.mem        (mem_bus.ctrl),
		.ld         (ld_bus.ctrl),
		.step       (step_bus.ctrl)
	);

	mat_store mat_store_inst (
		.clk (clk),
		.mem (mem_bus.store)
	);

	// --------------------
	// Datapath
	operand_regs operand_regs_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.mem    (mem_bus.sink),
		.ld     (ld_bus.regs),
		.step   (step_bus.regs),
		.a_row  (a_row),
		.b_col  (b_col),
		.c_elem (c_elem)
	);

	trace_mac trace_mac_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.step      (step_bus.mac),
		.a_row     (a_row),
		.b_col     (b_col),
		.c_elem    (c_elem),
		.res_done  (res_done),
		.out_valid (out_valid),
		.out_value (out_value)
	);

endmodule

// ==== bench/mmt_model.svh ====
`ifndef MMT_MODEL_SVH
`define MMT_MODEL_SVH

// Expected sum over i,j of (A*B)[i][j] * C[i][j]
// Mode 1 transposes A, 2 transposes B, 3 transposes C
function automatic mmt_pkg::result_t trace_ref(
	input mmt_pkg::elem_t bank [mmt_pkg::STORE_DEPTH],
	input int             ia,
	input int             ib,
	input int             ic,
	input int             md
);
	int a [mmt_pkg::DIM][mmt_pkg::DIM];
	int b [mmt_pkg::DIM][mmt_pkg::DIM];
	int c [mmt_pkg::DIM][mmt_pkg::DIM];
	int base_a;
	int base_b;
	int base_c;
	int dot;
	int total;

	base_a = ia * mmt_pkg::ELEMS;
	base_b = ib * mmt_pkg::ELEMS;
	base_c = ic * mmt_pkg::ELEMS;

	// Row-major in the bank, swap row and column for the transposed operand
	for (int r = 0; r < mmt_pkg::DIM; r++) begin
		for (int k = 0; k < mmt_pkg::DIM; k++) begin
			a[r][k] = (md == 1) ? int'(bank[base_a + k * mmt_pkg::DIM + r]) :
				int'(bank[base_a + r * mmt_pkg::DIM + k]);
			b[r][k] = (md == 2) ? int'(bank[base_b + k * mmt_pkg::DIM + r]) :
				int'(bank[base_b + r * mmt_pkg::DIM + k]);
			c[r][k] = (md == 3) ? int'(bank[base_c + k * mmt_pkg::DIM + r]) :
				int'(bank[base_c + r * mmt_pkg::DIM + k]);
		end
	end

	total = 0;
	for (int i = 0; i < mmt_pkg::DIM; i++) begin
		for (int j = 0; j < mmt_pkg::DIM; j++) begin
			dot = 0;
			for (int k = 0; k < mmt_pkg::DIM; k++)
				dot = dot + a[i][k] * b[k][j];
			total = total + dot * c[i][j];
		end
	end
	return mmt_pkg::result_t'(total);
endfunction

`endif

// ==== bench/mmt_tb.sv ====
`timescale 1ns/1ps

module mmt_tb;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              in_valid;
	mmt_pkg::elem_t    matrix;
	logic              in_valid2;
	mmt_pkg::mat_idx_t matrix_idx;
	mmt_pkg::mode_t    mode;
	logic              out_valid;
	mmt_pkg::result_t  out_value;

	mmt_pkg::elem_t   bank_copy [mmt_pkg::STORE_DEPTH];
	mmt_pkg::result_t exp_q [$];
	int               issued;
	int               pulses;

	`include "mmt_model.svh"

	mmt_top mmt_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.matrix     (matrix),
		.in_valid2  (in_valid2),
		.matrix_idx (matrix_idx),
		.mode       (mode),
		.out_valid  (out_valid),
		.out_value  (out_value)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	// --------------------
	// Failure handling
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
	endtask

	// Results are counted by the compare process
	task automatic wait_results();
		int waited;
		waited = 0;
		while (pulses != issued) begin
			@(posedge clk);
			waited++;
			if (waited > 1000)
				abort_run("timeout while waiting for out_valid");
		end
	endtask

	// --------------------
	// Stimulus
	task automatic load_bank(input bit use_random, input mmt_pkg::elem_t fill);
		for (int a = 0; a < mmt_pkg::STORE_DEPTH; a++)
			bank_copy[a] = use_random ? mmt_pkg::elem_t'($urandom) : fill;
		for (int a = 0; a < mmt_pkg::STORE_DEPTH; a++) begin
			@(posedge clk);
			#10;
			in_valid = 1'b1;
			matrix   = bank_copy[a];
		end
		@(posedge clk);
		#10;
		in_valid = 1'b0;
		matrix   = '0;
	endtask

	task automatic run_query(input int ia, input int ib, input int ic, input int md);
		int idx [3];
		idx[0] = ia;
		idx[1] = ib;
		idx[2] = ic;
		exp_q.push_back(trace_ref(bank_copy, ia, ib, ic, md));
		issued++;
		for (int k = 0; k < 3; k++) begin
			@(posedge clk);
			#10;
			in_valid2  = 1'b1;
			matrix_idx = mmt_pkg::mat_idx_t'(idx[k]);
			// Mode only counts on the first cycle
			mode       = (k == 0) ? mmt_pkg::mode_t'(md) : mmt_pkg::mode_t'(3 - md);
		end
		@(posedge clk);
		#10;
		in_valid2  = 1'b0;
		matrix_idx = '0;
		mode       = '0;
		wait_results();
	endtask

	// Negative md draws a random mode too
	task automatic run_random_query(input int md);
		int ia;
		int ib;
		int ic;
		int m;
		ia = $urandom % mmt_pkg::NUM_MAT;
		ib = $urandom % mmt_pkg::NUM_MAT;
		ic = $urandom % mmt_pkg::NUM_MAT;
		m  = (md < 0) ? ($urandom % 4) : md;
		run_query(ia, ib, ic, m);
	endtask

	// --------------------
	// Compare
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0)
				abort_run("out_valid pulse arrived with no query pending");
			else
				check_value("out_value", exp_q.pop_front(), out_value);
			pulses++;
		end else if (out_valid === 1'b0) begin
			check_value("out_value", '0, out_value);
		end else begin
			abort_run("out_valid is unknown");
		end
	end

	initial begin
		int edge_a [10];
		int edge_b [10];
		int edge_c [10];
		void'($urandom(38));
		edge_a     = '{0, 7, 0, 7, 3, 0, 7, 2, 0, 7};
		edge_b     = '{0, 7, 7, 0, 3, 0, 7, 5, 7, 0};
		edge_c     = '{0, 7, 0, 7, 5, 7, 0, 2, 7, 0};
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		matrix     = '0;
		in_valid2  = 1'b0;
		matrix_idx = '0;
		mode       = '0;
		issued     = 0;
		pulses     = 0;
		repeat (8) @(posedge clk);
		#10;
		rst_n = 1'b1;

		// Plain product, no transpose
		load_bank(1'b1, '0);
		for (int q = 0; q < mmt_pkg::QUERIES; q++)
			run_random_query(0);

		// Each transpose in turn
		load_bank(1'b1, '0);
		for (int q = 0; q < mmt_pkg::QUERIES; q++)
			run_random_query(q % 3 + 1);

		// Extremes
		load_bank(1'b0, mmt_pkg::elem_t'(-128));
		for (int q = 0; q < mmt_pkg::QUERIES; q++)
			run_random_query(-1);
		load_bank(1'b0, mmt_pkg::elem_t'(127));
		for (int q = 0; q < mmt_pkg::QUERIES; q++)
			run_random_query(-1);

		// Shared operands and the ends of the bank
		load_bank(1'b1, '0);
		for (int q = 0; q < mmt_pkg::QUERIES; q++)
			run_query(edge_a[q], edge_b[q], edge_c[q], q % 4);

		// Window for a stray pulse after the last result
		repeat (20) @(posedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== mmt_top.f ====
+incdir+bench
logic/mmt_pkg.sv
logic/mmt_ifs.sv
logic/mat_store.sv
logic/operand_regs.sv
logic/trace_mac.sv
logic/mmt_ctrl.sv
logic/mmt_top.sv
bench/mmt_tb.sv
